// File: dv/alu_cases.txt
# Columns, all hex: operation code, operand A, operand B, expected result, expected branch bit
# Operation codes follow the OP_ numbering of the ALU package
00 12345678 87654321 99999999 1
00 ffffffff 00000002 00000001 1
01 00000005 00000007 fffffffe 1
01 80000000 00000001 7fffffff 1
25 40000001 00000010 80000012 1
26 40000003 00000004 00000010 1
27 00000011 00000001 00000089 1
02 ff00ff00 0f0f0f0f f00ff00f 1
03 ff00ff00 0f0f0f0f ff0fff0f 1
04 ff00ff00 0f0f0f0f 0f000f00 1
05 ff00ff00 0f0f0f0f 0ff00ff0 1
06 ff00ff00 0f0f0f0f fff0fff0 1
07 ff00ff00 0f0f0f0f f000f000 1
08 a5a5a5a5 00000000 a5a5a5a5 1
08 80000001 00000001 00000002 1
08 00000003 ffffffff 80000000 1
09 80000000 00000001 40000000 1
09 f0000000 00000021 78000000 1
0a 80000000 0000001f ffffffff 1
0a 8000f000 00000004 f8000f00 1
0a 7fffffff 0000001f 00000000 1
0b 80000001 00000001 00000003 1
0b 12345678 00000020 12345678 1
0c 12345678 00000004 81234567 1
0c 00000001 0000001f 00000002 1
0d ffffffff 00000001 00000001 1
0e ffffffff 00000001 00000000 1
0f 00001234 00001234 00000000 1
10 00001234 00001234 00000000 0
0f 00000001 00000002 00000000 0
10 00000001 00000002 00000000 1
11 80000000 7fffffff 00000000 1
12 80000000 7fffffff 00000000 0
13 80000000 7fffffff 00000000 0
14 80000000 7fffffff 00000000 1
15 fffffff0 00000010 fffffff0 1
16 fffffff0 00000010 00000010 1
17 fffffff0 00000010 00000010 1
18 fffffff0 00000010 fffffff0 1
19 00010000 00000000 0000000f 1
19 00000000 00000000 00000020 1
19 ffffffff 00000000 00000000 1
1a 00010000 00000000 00000010 1
1a 00000000 00000000 00000020 1
1a ffffffff 00000000 00000000 1
1b ffffffff 00000000 00000020 1
1b f0f0000f 00000000 0000000c 1
1b 00000000 00000000 00000000 1
1c 12345680 00000000 ffffff80 1
1d 00008001 00000000 ffff8001 1
1e ffff8001 00000000 00008001 1
1f 00100f00 00000000 00ffff00 1
20 12345678 00000000 78563412 1
21 00000000 00000000 00000001 1
21 00000000 00000023 00000008 1
22 ffffffff 0000001f 7fffffff 1
23 00000000 00000021 00000002 1
24 80000000 0000001f 00000001 1
24 7fffffff 0000003f 00000000 1

// File: list.f
rtl/alu_pkg.sv
rtl/alu_decode_stage.sv
rtl/alu_adder_cmp.sv
rtl/alu_shifter.sv
rtl/alu_bit_count.sv
rtl/alu_result_stage.sv
rtl/alu_top.sv
dv/alu_tb.sv

// File: Bender.yml
package:
  name: alu

sources:
  - rtl/alu_pkg.sv
  - rtl/alu_decode_stage.sv
  - rtl/alu_adder_cmp.sv
  - rtl/alu_shifter.sv
  - rtl/alu_bit_count.sv
  - rtl/alu_result_stage.sv
  - rtl/alu_top.sv
  - target: test
    files:
      - dv/alu_tb.sv

// File: dv/alu_tb.sv
// ALU testbench with case file reader, stimulus driver and in-order output checker
module alu_tb;
  import alu_pkg::*;

  localparam logic [15:0] LFSR_SEED = 16'd98;

  logic    clk_i;
  logic    reset_i;
  logic    valid_i;
  alu_op_t op_i;
  word_t   operand_a_i;
  word_t   operand_b_i;
  logic    valid_o;
  word_t   result_o;
  logic    branch_res_o;

  // Cases as read from the file
  alu_op_t case_op[$];
  word_t   case_a[$];
  word_t   case_b[$];
  word_t   case_res[$];
  logic    case_br[$];

  // Expected outputs in issue order
  word_t exp_result_q[$];
  logic  exp_branch_q[$];
  int    exp_edge_q[$];
  int    exp_idx_q[$];

  int          cycle_count   = 0;
  int          timeout_limit = 20;
  int          value_errors  = 0;
  int          other_errors  = 0;
  int          checked       = 0;
  logic [15:0] lfsr_state    = LFSR_SEED;

  alu_top i_alu_top (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .valid_i     (valid_i),
    .op_i        (op_i),
    .operand_a_i (operand_a_i),
    .operand_b_i (operand_b_i),
    .valid_o     (valid_o),
    .result_o    (result_o),
    .branch_res_o(branch_res_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #20 clk_i = ~clk_i;
  end

  always @(posedge clk_i) begin
    cycle_count <= cycle_count + 1;
  end

  // --------------------------------------------------------------------------
  // Helpers
  // --------------------------------------------------------------------------
  // Taps 16, 15, 13, 4
  function automatic logic [15:0] lfsr_next(input logic [15:0] state);
    logic feedback;
    feedback = state[15] ^ state[14] ^ state[12] ^ state[3];
    return {state[14:0], feedback};
  endfunction

  function automatic int unsigned draw_bits(input int n);
    int unsigned value;
    value = 0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = lfsr_next(lfsr_state);
      value = (value << 1) | lfsr_state[0];
    end
    return value;
  endfunction

  task automatic read_cases();
    int                 fd;
    int                 status;
    logic [8*128-1:0]   line;
    logic [31:0]        f_op;
    logic [31:0]        f_a;
    logic [31:0]        f_b;
    logic [31:0]        f_res;
    logic [31:0]        f_br;
    fd = $fopen("dv/alu_cases.txt", "r");
    assert (fd != 0) else begin
      $display("Could not open the case file dv/alu_cases.txt");
      other_errors++;
    end
    if (fd != 0) begin
      while (!$feof(fd)) begin
        line = '0;
        status = $fgets(line, fd);
        // Comment and blank lines do not parse
        if (status != 0 &&
            $sscanf(line, "%h %h %h %h %h", f_op, f_a, f_b, f_res, f_br) == 5) begin
          case_op.push_back(alu_op_t'(f_op));
          case_a.push_back(f_a);
          case_b.push_back(f_b);
          case_res.push_back(f_res);
          case_br.push_back(f_br[0]);
        end
      end
      $fclose(fd);
    end
    assert (case_op.size() > 0) else begin
      $display("The case file holds no cases");
      other_errors++;
    end
  endtask

  // Called right after a rising edge, so cycle_count still holds the previous edge
  task automatic issue_case(input int idx);
    valid_i     <= 1'b1;
    op_i        <= case_op[idx];
    operand_a_i <= case_a[idx];
    operand_b_i <= case_b[idx];
    exp_result_q.push_back(case_res[idx]);
    exp_branch_q.push_back(case_br[idx]);
    exp_edge_q.push_back(cycle_count + 1);
    exp_idx_q.push_back(idx);
  endtask

  task automatic check_output();
    word_t exp_result;
    logic  exp_branch;
    int    exp_edge;
    int    idx;
    exp_result = exp_result_q.pop_front();
    exp_branch = exp_branch_q.pop_front();
    exp_edge   = exp_edge_q.pop_front();
    idx        = exp_idx_q.pop_front();
    // Sampled one edge after the drive, then one more edge through the result stage
    assert (cycle_count == exp_edge + 2) else begin
      $display("Case %0d came out at cycle %0d instead of cycle %0d",
               idx, cycle_count, exp_edge + 2);
      other_errors++;
    end
    assert (result_o === exp_result) else begin
      $display("CHECK FAILED time=%0t signal=result_o expected=%h actual=%h case=%0d",
               $time, exp_result, result_o, idx);
      value_errors++;
    end
    assert (branch_res_o === exp_branch) else begin
      $display("CHECK FAILED time=%0t signal=branch_res_o expected=%b actual=%b case=%0d",
               $time, exp_branch, branch_res_o, idx);
      value_errors++;
    end
    checked++;
  endtask

  task automatic report_counts();
    $display("Outputs checked: %0d, value mismatches: %0d, other errors: %0d",
             checked, value_errors, other_errors);
  endtask

  // --------------------------------------------------------------------------
  // Output checking
  // --------------------------------------------------------------------------
  always @(negedge clk_i) begin
    if (reset_i) begin
      assert (valid_o === 1'b0) else begin
        $display("valid_o is not low during reset at time %0t", $time);
        other_errors++;
      end
    end else if (valid_o === 1'b1) begin
      assert (exp_result_q.size() != 0) else begin
        $display("valid_o went high at time %0t with no case in flight", $time);
        other_errors++;
      end
      if (exp_result_q.size() != 0) begin
        check_output();
      end
    end else begin
      assert (valid_o === 1'b0) else begin
        $display("valid_o is unknown at time %0t", $time);
        other_errors++;
      end
    end
  end

  always @(posedge clk_i) begin
    if (cycle_count >= timeout_limit) begin
      $display("Timeout after %0d cycles with %0d cases still in flight",
               cycle_count, exp_result_q.size());
      report_counts();
      $display("TEST RESULT: FAIL");
      $finish;
    end
  end

  // --------------------------------------------------------------------------
  // Stimulus
  // --------------------------------------------------------------------------
  initial begin
    reset_i     = 1'b1;
    valid_i     = 1'b0;
    op_i        = '0;
    operand_a_i = '0;
    operand_b_i = '0;
    read_cases();
    timeout_limit = 4 * case_op.size() + 20;

    repeat (2) @(posedge clk_i);
    reset_i <= 1'b0;

    for (int i = 0; i < case_op.size(); i++) begin
      @(posedge clk_i);
      issue_case(i);
      // Zero to three idle cycles
      repeat (draw_bits(2)) begin
        @(posedge clk_i);
        valid_i <= 1'b0;
      end
    end
    @(posedge clk_i);
    valid_i <= 1'b0;

    // Drain, then watch for stray strobes
    while (exp_result_q.size() != 0) @(posedge clk_i);
    repeat (3) @(negedge clk_i);

    report_counts();
    if (value_errors == 0 && other_errors == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

// File: rtl/alu_top.sv
// ALU top level with decode stage, execution units and result stage
module alu_top (
  input  logic             clk_i,
  input  logic             reset_i,
  input  logic             valid_i,
  input  alu_pkg::alu_op_t op_i,
  input  alu_pkg::word_t   operand_a_i,
  input  alu_pkg::word_t   operand_b_i,
  output logic             valid_o,
  output alu_pkg::word_t   result_o,
  output logic             branch_res_o
);
  import alu_pkg::*;

  // Decode stage registers
  logic    dec_valid;
  alu_op_t dec_op;
  word_t   dec_operand_a;
  word_t   dec_operand_b;
  word_t   dec_adder_a;
  logic    dec_negate_b;
  logic    dec_signed_cmp;
  logic    dec_shift_left;
  logic    dec_shift_arith;
  logic    dec_rotate;
  word_t   dec_count_src;

  // Execution unit outputs
  word_t  sum;
  word_t  b_eff;
  logic   zero;
  logic   less;
  word_t  shift_res;
  count_t lz_count;
  count_t pop_count;

  // --------------------------------------------------------------------------
  // Stage 1
  // --------------------------------------------------------------------------
  alu_decode_stage i_decode (
    .clk_i        (clk_i),
    .reset_i      (reset_i),
    .valid_i      (valid_i),
    .op_i         (op_i),
    .operand_a_i  (operand_a_i),
    .operand_b_i  (operand_b_i),
    .valid_o      (dec_valid),
    .op_o         (dec_op),
    .operand_a_o  (dec_operand_a),
    .operand_b_o  (dec_operand_b),
    .adder_a_o    (dec_adder_a),
    .negate_b_o   (dec_negate_b),
    .signed_cmp_o (dec_signed_cmp),
    .shift_left_o (dec_shift_left),
    .shift_arith_o(dec_shift_arith),
    .rotate_o     (dec_rotate),
    .count_src_o  (dec_count_src)
  );

  // --------------------------------------------------------------------------
  // Execution units
  // --------------------------------------------------------------------------
  alu_adder_cmp i_adder_cmp (
    .adder_a_i   (dec_adder_a),
    .operand_a_i (dec_operand_a),
    .operand_b_i (dec_operand_b),
    .negate_b_i  (dec_negate_b),
    .signed_cmp_i(dec_signed_cmp),
    .sum_o       (sum),
    .b_eff_o     (b_eff),
    .zero_o      (zero),
    .less_o      (less)
  );

  // Amount is the low five bits of B
  alu_shifter i_shifter (
    .operand_a_i  (dec_operand_a),
    .shamt_i      (dec_operand_b[SHAMT_W-1:0]),
    .shift_left_i (dec_shift_left),
    .shift_arith_i(dec_shift_arith),
    .rotate_i     (dec_rotate),
    .shift_o      (shift_res)
  );

  alu_bit_count i_bit_count (
    .count_src_i(dec_count_src),
    .lz_count_o (lz_count),
    .pop_count_o(pop_count)
  );

  // --------------------------------------------------------------------------
  // Stage 2
  // --------------------------------------------------------------------------
  alu_result_stage i_result (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .valid_i     (dec_valid),
    .op_i        (dec_op),
    .operand_a_i (dec_operand_a),
    .operand_b_i (dec_operand_b),
    .sum_i       (sum),
    .b_eff_i     (b_eff),
    .zero_i      (zero),
    .less_i      (less),
    .shift_i     (shift_res),
    .lz_count_i  (lz_count),
    .pop_count_i (pop_count),
    .valid_o     (valid_o),
    .result_o    (result_o),
    .branch_res_o(branch_res_o)
  );

endmodule

// File: rtl/alu_result_stage.sv
// Result select, local bit operations and branch resolve of the second ALU stage
module alu_result_stage (
  input  logic             clk_i,
  input  logic             reset_i,
  input  logic             valid_i,
  input  alu_pkg::alu_op_t op_i,
  input  alu_pkg::word_t   operand_a_i,
  input  alu_pkg::word_t   operand_b_i,
  input  alu_pkg::word_t   sum_i,
  input  alu_pkg::word_t   b_eff_i,
  input  logic             zero_i,
  input  logic             less_i,
  input  alu_pkg::word_t   shift_i,
  input  alu_pkg::count_t  lz_count_i,
  input  alu_pkg::count_t  pop_count_i,
  output logic             valid_o,
  output alu_pkg::word_t   result_o,
  output logic             branch_res_o
);
  import alu_pkg::*;

  word_t bit_onehot;
  word_t orcb;
  word_t rev8;
  word_t result;
  logic  branch_res;

  // --------------------------------------------------------------------------
  // Local operations
  // --------------------------------------------------------------------------
  // Bit index is B modulo XLEN
  assign bit_onehot = word_t'(1) << operand_b_i[SHAMT_W-1:0];

  always_comb begin
    for (int i = 0; i < XLEN / 8; i++) begin
      orcb[8*i +: 8] = {8{|operand_a_i[8*i +: 8]}};
      rev8[8*i +: 8] = operand_a_i[XLEN-8-8*i +: 8];
    end
  end

  // --------------------------------------------------------------------------
  // Result select
  // --------------------------------------------------------------------------
  // Branch compares fall to the default and give zero
  always_comb begin
    unique case (op_i)
      OP_ADD, OP_SUB, OP_SH1ADD, OP_SH2ADD, OP_SH3ADD: result = sum_i;
      OP_ANDL, OP_ANDN: result = operand_a_i & b_eff_i;
      OP_ORL, OP_ORN:   result = operand_a_i | b_eff_i;
      OP_XORL, OP_XNOR: result = operand_a_i ^ b_eff_i;
      OP_SLL, OP_SRL, OP_SRA, OP_ROL, OP_ROR: result = shift_i;
      OP_SLTS, OP_SLTU: result = {{(XLEN-1){1'b0}}, less_i};
      OP_MIN, OP_MINU:  result = less_i ? operand_a_i : operand_b_i;
      OP_MAX, OP_MAXU:  result = less_i ? operand_b_i : operand_a_i;
      OP_CLZ, OP_CTZ:   result = {{(XLEN-CNT_W){1'b0}}, lz_count_i};
      OP_CPOP:          result = {{(XLEN-CNT_W){1'b0}}, pop_count_i};
      OP_SEXTB: result = {{(XLEN-8){operand_a_i[7]}}, operand_a_i[7:0]};
      OP_SEXTH: result = {{(XLEN-16){operand_a_i[15]}}, operand_a_i[15:0]};
      OP_ZEXTH: result = {{(XLEN-16){1'b0}}, operand_a_i[15:0]};
      OP_ORCB:  result = orcb;
      OP_REV8:  result = rev8;
      OP_BSET:  result = operand_a_i | bit_onehot;
      OP_BCLR:  result = operand_a_i & ~bit_onehot;
      OP_BINV:  result = operand_a_i ^ bit_onehot;
      OP_BEXT:  result = {{(XLEN-1){1'b0}}, |(operand_a_i & bit_onehot)};
      default:  result = '0;
    endcase
  end

  // Branch outcome is 1 for everything that is not a compare
  always_comb begin
    unique case (op_i)
      OP_EQ:          branch_res = zero_i;
      OP_NE:          branch_res = ~zero_i;
      OP_LTS, OP_LTU: branch_res = less_i;
      OP_GES, OP_GEU: branch_res = ~less_i;
      default:        branch_res = 1'b1;
    endcase
  end

  // --------------------------------------------------------------------------
  // Output registers
  // --------------------------------------------------------------------------
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      valid_o <= 1'b0;
    end else begin
      valid_o <= valid_i;
    end
  end

  always_ff @(posedge clk_i) begin
    result_o     <= result;
    branch_res_o <= branch_res;
  end

endmodule

// File: rtl/alu_bit_count.sv
// Leading-zero counter and population counter
module alu_bit_count (
  input  alu_pkg::word_t  count_src_i,
  output alu_pkg::count_t lz_count_o,
  output alu_pkg::count_t pop_count_o
);
  import alu_pkg::*;

  count_t lz_count;
  count_t pop_count;

  // --------------------------------------------------------------------------
  // Leading zeros
  // --------------------------------------------------------------------------
  // Scan upwards so the highest set bit wins.
  // An all-zero source keeps the default of XLEN.
  always_comb begin
    lz_count = count_t'(XLEN);
    for (int i = 0; i < XLEN; i++) begin
      if (count_src_i[i]) begin
        lz_count = count_t'(XLEN - 1 - i);
      end
    end
  end

  // --------------------------------------------------------------------------
  // Population count
  // --------------------------------------------------------------------------
  always_comb begin
    pop_count = '0;
    for (int i = 0; i < XLEN; i++) begin
      pop_count = pop_count + count_t'(count_src_i[i]);
    end
  end

  assign lz_count_o  = lz_count;
  assign pop_count_o = pop_count;

endmodule

// File: rtl/alu_shifter.sv
// Shift and rotate unit around a single right shifter
module alu_shifter (
  input  alu_pkg::word_t  operand_a_i,
  input  alu_pkg::shamt_t shamt_i,
  input  logic            shift_left_i,
  input  logic            shift_arith_i,
  input  logic            rotate_i,
  output alu_pkg::word_t  shift_o
);
  import alu_pkg::*;

  word_t         shift_in;
  logic [XLEN:0] shift_in_ext;
  logic [XLEN:0] shift_right;
  shamt_t        wrap_amt;
  word_t         wrap_bits;
  word_t         shift_raw;

  // --------------------------------------------------------------------------
  // Input side
  // --------------------------------------------------------------------------
  // Left shifts run mirrored through the right shifter
  assign shift_in = shift_left_i ? reverse_bits(operand_a_i) : operand_a_i;

  // Top bit is the sign for SRA and zero otherwise
  assign shift_in_ext = {shift_arith_i & shift_in[XLEN-1], shift_in};

  assign shift_right = $unsigned($signed(shift_in_ext) >>> shamt_i);

  // --------------------------------------------------------------------------
  // Rotate fill
  // --------------------------------------------------------------------------
  // Bits pushed out at the bottom reappear at the top.
  // Amount wraps to 0 for a zero shift, which ORs the word with itself.
  assign wrap_amt  = shamt_t'(~shamt_i + 1'b1);
  assign wrap_bits = rotate_i ? (shift_in << wrap_amt) : '0;

  assign shift_raw = shift_right[XLEN-1:0] | wrap_bits;

  // Undo the mirroring
  assign shift_o = shift_left_i ? reverse_bits(shift_raw) : shift_raw;

endmodule

// File: rtl/alu_adder_cmp.sv
// Shared adder with operand B negation, zero flag and less-than compare
module alu_adder_cmp (
  input  alu_pkg::word_t adder_a_i,
  input  alu_pkg::word_t operand_a_i,
  input  alu_pkg::word_t operand_b_i,
  input  logic           negate_b_i,
  input  logic           signed_cmp_i,
  output alu_pkg::word_t sum_o,
  output alu_pkg::word_t b_eff_o,
  output logic           zero_o,
  output logic           less_o
);
  import alu_pkg::*;

  word_t         b_eff;
  logic [XLEN:0] adder_in_a;
  logic [XLEN:0] adder_in_b;
  logic [XLEN:0] adder_sum;
  logic [XLEN:0] cmp_a;
  logic [XLEN:0] cmp_b;

  // Inverted B is also the operand of ANDN, ORN and XNOR
  assign b_eff   = negate_b_i ? ~operand_b_i : operand_b_i;
  assign b_eff_o = b_eff;

  // --------------------------------------------------------------------------
  // Adder
  // --------------------------------------------------------------------------
  // Extra low bit turns the negation into a two's complement carry-in
  assign adder_in_a = {adder_a_i, 1'b1};
  assign adder_in_b = {b_eff, negate_b_i};
  assign adder_sum  = adder_in_a + adder_in_b;

  assign sum_o  = adder_sum[XLEN:1];
  assign zero_o = ~|adder_sum[XLEN:1];

  // --------------------------------------------------------------------------
  // Compare
  // --------------------------------------------------------------------------
  // Sign bit extended only for signed compares
  assign cmp_a = {signed_cmp_i & operand_a_i[XLEN-1], operand_a_i};
  assign cmp_b = {signed_cmp_i & operand_b_i[XLEN-1], operand_b_i};

  assign less_o = $signed(cmp_a) < $signed(cmp_b);

endmodule

// File: rtl/alu_decode_stage.sv
// Operation decode, operand preparation and stage registers of the first ALU stage
module alu_decode_stage (
  input  logic             clk_i,
  input  logic             reset_i,
  input  logic             valid_i,
  input  alu_pkg::alu_op_t op_i,
  input  alu_pkg::word_t   operand_a_i,
  input  alu_pkg::word_t   operand_b_i,
  output logic             valid_o,
  output alu_pkg::alu_op_t op_o,
  output alu_pkg::word_t   operand_a_o,
  output alu_pkg::word_t   operand_b_o,
  output alu_pkg::word_t   adder_a_o,
  output logic             negate_b_o,
  output logic             signed_cmp_o,
  output logic             shift_left_o,
  output logic             shift_arith_o,
  output logic             rotate_o,
  output alu_pkg::word_t   count_src_o
);
  import alu_pkg::*;

  word_t adder_a;
  word_t count_src;
  logic  negate_b;
  logic  signed_cmp;
  logic  shift_left;
  logic  shift_arith;
  logic  rotate;

  // --------------------------------------------------------------------------
  // Control flags
  // --------------------------------------------------------------------------
  // Compares go through the subtractor for the zero flag
  assign negate_b = op_i inside {OP_SUB, OP_EQ, OP_NE, OP_LTS, OP_LTU, OP_GES, OP_GEU,
                                 OP_ANDN, OP_ORN, OP_XNOR};
  assign signed_cmp  = op_i inside {OP_SLTS, OP_LTS, OP_GES, OP_MIN, OP_MAX};
  assign shift_left  = op_i inside {OP_SLL, OP_ROL};
  assign shift_arith = (op_i == OP_SRA);
  assign rotate      = op_i inside {OP_ROL, OP_ROR};

  // Pre-shift for SHnADD
  always_comb begin
    unique case (op_i)
      OP_SH1ADD: adder_a = operand_a_i << 1;
      OP_SH2ADD: adder_a = operand_a_i << 2;
      OP_SH3ADD: adder_a = operand_a_i << 3;
      default:   adder_a = operand_a_i;
    endcase
  end

  // CTZ reuses the leading-zero counter on the mirrored word
  assign count_src = (op_i == OP_CTZ) ? reverse_bits(operand_a_i) : operand_a_i;

  // --------------------------------------------------------------------------
  // Stage registers
  // --------------------------------------------------------------------------
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      valid_o <= 1'b0;
    end else begin
      valid_o <= valid_i;
    end
  end

  always_ff @(posedge clk_i) begin
    op_o          <= op_i;
    operand_a_o   <= operand_a_i;
    operand_b_o   <= operand_b_i;
    adder_a_o     <= adder_a;
    negate_b_o    <= negate_b;
    signed_cmp_o  <= signed_cmp;
    shift_left_o  <= shift_left;
    shift_arith_o <= shift_arith;
    rotate_o      <= rotate;
    count_src_o   <= count_src;
  end

endmodule

// File: rtl/alu_pkg.sv
// Widths, word types, operation codes and bit reversal helper of the ALU
package alu_pkg;

  // --------------------------------------------------------------------------
  // Widths
  // --------------------------------------------------------------------------
  localparam int unsigned XLEN    = 32;
  localparam int unsigned SHAMT_W = 5;
  // Must hold 0 through XLEN
  localparam int unsigned CNT_W   = 6;
  localparam int unsigned OP_W    = 6;

  typedef logic [XLEN-1:0]    word_t;
  typedef logic [SHAMT_W-1:0] shamt_t;
  typedef logic [CNT_W-1:0]   count_t;
  typedef logic [OP_W-1:0]    alu_op_t;

  // --------------------------------------------------------------------------
  // Operation codes
  // --------------------------------------------------------------------------
  // Base integer operations
  localparam alu_op_t OP_ADD    = alu_op_t'(0);
  localparam alu_op_t OP_SUB    = alu_op_t'(1);
  localparam alu_op_t OP_XORL   = alu_op_t'(2);
  localparam alu_op_t OP_ORL    = alu_op_t'(3);
  localparam alu_op_t OP_ANDL   = alu_op_t'(4);
  localparam alu_op_t OP_XNOR   = alu_op_t'(5);
  localparam alu_op_t OP_ORN    = alu_op_t'(6);
  localparam alu_op_t OP_ANDN   = alu_op_t'(7);
  localparam alu_op_t OP_SLL    = alu_op_t'(8);
  localparam alu_op_t OP_SRL    = alu_op_t'(9);
  localparam alu_op_t OP_SRA    = alu_op_t'(10);
  localparam alu_op_t OP_ROL    = alu_op_t'(11);
  localparam alu_op_t OP_ROR    = alu_op_t'(12);
  localparam alu_op_t OP_SLTS   = alu_op_t'(13);
  localparam alu_op_t OP_SLTU   = alu_op_t'(14);

  // Branch compares
  localparam alu_op_t OP_EQ     = alu_op_t'(15);
  localparam alu_op_t OP_NE     = alu_op_t'(16);
  localparam alu_op_t OP_LTS    = alu_op_t'(17);
  localparam alu_op_t OP_LTU    = alu_op_t'(18);
  localparam alu_op_t OP_GES    = alu_op_t'(19);
  localparam alu_op_t OP_GEU    = alu_op_t'(20);

  // Bit manipulation subset
  localparam alu_op_t OP_MIN    = alu_op_t'(21);
  localparam alu_op_t OP_MAX    = alu_op_t'(22);
  localparam alu_op_t OP_MINU   = alu_op_t'(23);
  localparam alu_op_t OP_MAXU   = alu_op_t'(24);
  localparam alu_op_t OP_CLZ    = alu_op_t'(25);
  localparam alu_op_t OP_CTZ    = alu_op_t'(26);
  localparam alu_op_t OP_CPOP   = alu_op_t'(27);
  localparam alu_op_t OP_SEXTB  = alu_op_t'(28);
  localparam alu_op_t OP_SEXTH  = alu_op_t'(29);
  localparam alu_op_t OP_ZEXTH  = alu_op_t'(30);
  localparam alu_op_t OP_ORCB   = alu_op_t'(31);
  localparam alu_op_t OP_REV8   = alu_op_t'(32);
  localparam alu_op_t OP_BSET   = alu_op_t'(33);
  localparam alu_op_t OP_BCLR   = alu_op_t'(34);
  localparam alu_op_t OP_BINV   = alu_op_t'(35);
  localparam alu_op_t OP_BEXT   = alu_op_t'(36);
  localparam alu_op_t OP_SH1ADD = alu_op_t'(37);
  localparam alu_op_t OP_SH2ADD = alu_op_t'(38);
  localparam alu_op_t OP_SH3ADD = alu_op_t'(39);

  // --------------------------------------------------------------------------
  // Helpers
  // --------------------------------------------------------------------------
  // Mirror a word so that bit 0 becomes bit XLEN-1
  function automatic word_t reverse_bits(input word_t value);
    word_t rev;
    for (int i = 0; i < XLEN; i++) begin
      rev[i] = value[XLEN-1-i];
    end
    return rev;
  endfunction

endpackage
